// File: design/cw_keyer_pkg.sv
package cw_keyer_pkg;

  localparam int clks_per_ms     = 20;
  localparam int debounce_cycles = 8;
  localparam int dot_constant    = 1200;
  localparam int weight_unit     = 50;   // Weight at which w equals d

  localparam int presc_w = $clog2(clks_per_ms);
  localparam logic [presc_w-1:0] presc_last = presc_w'(clks_per_ms - 1);
  localparam int dbc_w = $clog2(debounce_cycles);
  localparam logic [dbc_w-1:0] debounce_last = dbc_w'(debounce_cycles - 1);
  localparam int div_w = 14;             // Dividend width, holds d*weight
  localparam logic [3:0] div_last = 4'(div_w - 1);

  localparam logic [5:0] speed_min  = 6'd5;
  localparam logic [5:0] speed_rst  = 6'd20;
  localparam logic [6:0] weight_min = 7'd33;
  localparam logic [6:0] weight_max = 7'd66;
  localparam logic [6:0] weight_rst = 7'd50;

  localparam logic [3:0] reg_ctrl   = 4'h0;
  localparam logic [3:0] reg_weight = 4'h4;
  localparam logic [3:0] reg_hang   = 4'h8;
  localparam logic [3:0] reg_status = 4'hC;

  localparam logic [1:0] axi_resp_okay   = 2'b00;
  localparam logic [1:0] axi_resp_slverr = 2'b10;

  typedef enum logic [1:0] {
    mode_straight = 2'd0,
    mode_iambic_a = 2'd1,
    mode_iambic_b = 2'd2
  } keyer_mode_e;

  typedef enum logic [1:0] {elem_dot, elem_dash, elem_space, elem_letter_gap} element_kind_e;

  typedef enum logic [2:0] {st_idle, st_straight, st_mark, st_gap, st_letter} keyer_state_e;

endpackage

// File: design/keyer_cfg_if.sv
`timescale 1ns/10ps

interface keyer_cfg_if;
  logic [5:0]                speed;    // WPM
  cw_keyer_pkg::keyer_mode_e mode;
  logic                      reverse;  // Paddle swap
  logic                      spacing;  // Letter spacing enable
  logic [6:0]                weight;
  logic [9:0]                hang_ms;

  modport src (
    output speed, mode, reverse, spacing, weight, hang_ms
  );

  modport snk (
    input speed, mode, reverse, spacing, weight, hang_ms
  );
endinterface

// File: design/element_if.sv
`timescale 1ns/10ps

interface element_if;
  logic                        start;  // One cycle request
  cw_keyer_pkg::element_kind_e kind;
  logic                        done;   // One cycle, ends the element
  logic                        busy;

  modport ctrl (output start, kind, input done, busy);

  modport timer (input start, kind, output done, busy);
endinterface

// File: design/keyer_regs.sv
`timescale 1ns/10ps

module keyer_regs (
  input  logic        clk,
  input  logic        rst_n,
  input  logic [3:0]  awaddr,
  input  logic        awvalid,
  output logic        awready,
  input  logic [31:0] wdata,
  input  logic [3:0]  wstrb,
  input  logic        wvalid,
  output logic        wready,
  output logic [1:0]  bresp,
  output logic        bvalid,
  input  logic        bready,
  input  logic [3:0]  araddr,
  input  logic        arvalid,
  output logic        arready,
  output logic [31:0] rdata,
  output logic [1:0]  rresp,
  output logic        rvalid,
  input  logic        rready,
  input  logic        keydown,
  input  logic        power_on,
  input  logic        timer_busy,
  keyer_cfg_if.src    cfg
);

  logic [5:0]  speed_q;
  logic [1:0]  mode_q;
  logic        reverse_q;
  logic        spacing_q;
  logic [6:0]  weight_q;
  logic [9:0]  hang_q;
  logic [31:0] wmask;
  logic [32:0] wr_old;
  logic [32:0] rd_val;
  logic [31:0] wr_new;
  logic        wr_go;
  logic        wr_ok;
  logic        rd_go;

  // Bit 32 flags a mapped offset
  function automatic logic [32:0] reg_read(input logic [3:0] addr);
    logic [32:0] res;
    case (addr)
      cw_keyer_pkg::reg_ctrl:   res = {1'b1, 22'd0, spacing_q, reverse_q, mode_q, speed_q};
      cw_keyer_pkg::reg_weight: res = {1'b1, 25'd0, weight_q};
      cw_keyer_pkg::reg_hang:   res = {1'b1, 22'd0, hang_q};
      cw_keyer_pkg::reg_status: res = {1'b1, 29'd0, timer_busy, power_on, keydown};
      default:                  res = '0;
    endcase
    return res;
  endfunction

  assign wmask  = {{8{wstrb[3]}}, {8{wstrb[2]}}, {8{wstrb[1]}}, {8{wstrb[0]}}};
  assign wr_old = reg_read(awaddr);
  assign wr_new = (wr_old[31:0] & ~wmask) | (wdata & wmask);
  assign wr_ok  = wr_old[32] && (awaddr != cw_keyer_pkg::reg_status);
  assign wr_go  = awready & awvalid & wvalid;
  assign rd_val = reg_read(araddr);
  assign rd_go  = arready & arvalid;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      awready   <= 1'b0;
      wready    <= 1'b0;
      bvalid    <= 1'b0;
      arready   <= 1'b0;
      rvalid    <= 1'b0;
      speed_q   <= cw_keyer_pkg::speed_rst;
      mode_q    <= cw_keyer_pkg::mode_straight;
      reverse_q <= 1'b0;
      spacing_q <= 1'b0;
      weight_q  <= cw_keyer_pkg::weight_rst;
      hang_q    <= '0;
    end else begin
      awready <= awvalid & wvalid & ~awready & ~bvalid;  // AW and W taken together
      wready  <= awvalid & wvalid & ~awready & ~bvalid;
      arready <= arvalid & ~arready & ~rvalid;
      if (wr_go) begin
        bvalid <= 1'b1;
        if (wr_ok) begin
          case (awaddr)
            cw_keyer_pkg::reg_ctrl: begin
              speed_q   <= (wr_new[5:0] < cw_keyer_pkg::speed_min) ?
                           cw_keyer_pkg::speed_min : wr_new[5:0];
              mode_q    <= wr_new[7:6];
              reverse_q <= wr_new[8];
              spacing_q <= wr_new[9];
            end
            cw_keyer_pkg::reg_weight: begin
              if (wr_new[6:0] < cw_keyer_pkg::weight_min) weight_q <= cw_keyer_pkg::weight_min;
              else if (wr_new[6:0] > cw_keyer_pkg::weight_max) weight_q <= cw_keyer_pkg::weight_max;
              else weight_q <= wr_new[6:0];
            end
            default: hang_q <= wr_new[9:0];
          endcase
        end
      end else if (bready) begin
        bvalid <= 1'b0;
      end
      if (rd_go) begin
        rvalid <= 1'b1;
      end else if (rready) begin
        rvalid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (wr_go) bresp <= wr_ok ? cw_keyer_pkg::axi_resp_okay : cw_keyer_pkg::axi_resp_slverr;
    if (rd_go) begin
      rdata <= rd_val[31:0];  // Zero for unmapped offsets
      rresp <= rd_val[32] ? cw_keyer_pkg::axi_resp_okay : cw_keyer_pkg::axi_resp_slverr;
    end
  end

  assign cfg.speed   = speed_q;
  assign cfg.mode    = cw_keyer_pkg::keyer_mode_e'(mode_q);
  assign cfg.reverse = reverse_q;
  assign cfg.spacing = spacing_q;
  assign cfg.weight  = weight_q;
  assign cfg.hang_ms = hang_q;

  a_bvalid_hold: assert property (@(posedge clk) disable iff (!rst_n)
    bvalid && !bready |=> bvalid);

endmodule

// File: design/paddle_conditioner.sv
`timescale 1ns/10ps

module paddle_conditioner (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     dot_key,
  input  logic     dash_key,
  keyer_cfg_if.snk cfg,
  output logic     dot_clean,
  output logic     dash_clean
);

  // Index 0 is the dot contact, index 1 the dash contact
  logic [1:0] sync1;
  logic [1:0] sync2;
  logic [1:0] stable;
  logic [cw_keyer_pkg::dbc_w-1:0] cnt [2];

  always_ff @(posedge clk) begin
    sync1 <= {dash_key, dot_key};
    sync2 <= sync1;
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      stable <= 2'b00;
      cnt[0] <= '0;
      cnt[1] <= '0;
    end else begin
      for (int i = 0; i < 2; i++) begin
        if (sync2[i] == stable[i]) begin
          cnt[i] <= '0;
        end else if (cnt[i] == cw_keyer_pkg::debounce_last) begin
          stable[i] <= sync2[i];  // Level held long enough
          cnt[i]    <= '0;
        end else begin
          cnt[i] <= cnt[i] + 1'b1;
        end
      end
    end
  end

  assign dot_clean  = cfg.reverse ? stable[1] : stable[0];
  assign dash_clean = cfg.reverse ? stable[0] : stable[1];

endmodule

// File: design/element_timer.sv
`timescale 1ns/10ps

module element_timer (
  input  logic     clk,
  input  logic     rst_n,
  keyer_cfg_if.snk cfg,
  element_if.timer elem,
  output logic     ms_tick,
  output logic     timer_busy
);

  typedef enum logic [1:0] {ph_idle, ph_load, ph_div_d, ph_div_w} div_phase_e;

  div_phase_e                          phase;
  logic [5:0]                          speed_q;
  logic [6:0]                          weight_q;
  logic [5:0]                          divisor;
  logic [5:0]                          rem;
  logic [cw_keyer_pkg::div_w-1:0]      quo;
  logic [3:0]                          step;
  logic [6:0]                          rem_sh;
  logic [6:0]                          rem_diff;
  logic                                rem_ge;
  logic [cw_keyer_pkg::div_w-1:0]      quo_sh;
  logic [7:0]                          d_ms;
  logic [8:0]                          w_ms;
  logic [9:0]                          dur;
  logic [9:0]                          ms_left;
  logic [cw_keyer_pkg::presc_w-1:0]    presc;
  logic                                run;
  logic                                pending;
  logic                                launch;
  cw_keyer_pkg::element_kind_e         kind_q;
  cw_keyer_pkg::element_kind_e         launch_kind;

  // One restoring step per cycle, d first, then w
  assign rem_sh   = {rem, quo[cw_keyer_pkg::div_w-1]};
  assign rem_diff = rem_sh - {1'b0, divisor};
  assign rem_ge   = rem_sh >= {1'b0, divisor};
  assign quo_sh   = {quo[cw_keyer_pkg::div_w-2:0], rem_ge};

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      phase <= ph_load;
    end else begin
      case (phase)
        ph_idle:  if (cfg.speed != speed_q || cfg.weight != weight_q) phase <= ph_load;
        ph_load:  phase <= ph_div_d;
        ph_div_d: if (step == cw_keyer_pkg::div_last) phase <= ph_div_w;
        default:  if (step == cw_keyer_pkg::div_last) phase <= ph_idle;
      endcase
    end
  end

  always_ff @(posedge clk) begin
    if (phase == ph_load) begin
      speed_q  <= cfg.speed;
      weight_q <= cfg.weight;
      divisor  <= cfg.speed;
      quo      <= cw_keyer_pkg::div_w'(cw_keyer_pkg::dot_constant);
      rem      <= '0;
      step     <= '0;
    end else if (phase != ph_idle) begin
      rem  <= rem_ge ? rem_diff[5:0] : rem_sh[5:0];
      quo  <= quo_sh;
      step <= step + 1'b1;
      if (step == cw_keyer_pkg::div_last) begin
        rem  <= '0;
        step <= '0;
        if (phase == ph_div_d) begin
          d_ms    <= quo_sh[7:0];
          quo     <= cw_keyer_pkg::div_w'(quo_sh[7:0]) * weight_q;  // d*weight, then /50
          divisor <= 6'(cw_keyer_pkg::weight_unit);
        end else begin
          w_ms <= quo_sh[8:0];
        end
      end
    end
  end

  assign launch      = (elem.start | pending) & (phase == ph_idle);
  assign launch_kind = pending ? kind_q : elem.kind;

  always_comb begin
    case (launch_kind)
      cw_keyer_pkg::elem_dot:   dur = {1'b0, w_ms};
      cw_keyer_pkg::elem_dash:  dur = {1'b0, d_ms, 1'b0} + {1'b0, w_ms};
      cw_keyer_pkg::elem_space: dur = {1'b0, d_ms, 1'b0} - {1'b0, w_ms};
      default:                  dur = {1'b0, d_ms, 1'b0};
    endcase
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      run       <= 1'b0;
      pending   <= 1'b0;
      elem.done <= 1'b0;
      presc     <= '0;
      ms_left   <= '0;
    end else begin
      elem.done <= 1'b0;
      presc     <= ms_tick ? '0 : presc + 1'b1;
      if (launch) begin
        run     <= 1'b1;
        pending <= 1'b0;
        presc   <= '0;  // Element starts on a fresh ms boundary
        ms_left <= dur;
      end else begin
        if (elem.start) pending <= 1'b1;  // Wait for the divider
        if (run && ms_tick) begin
          ms_left <= ms_left - 1'b1;
          if (ms_left == 10'd1) begin
            run       <= 1'b0;
            elem.done <= 1'b1;
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (elem.start) kind_q <= elem.kind;
  end

  assign ms_tick    = presc == cw_keyer_pkg::presc_last;
  assign elem.busy  = run | pending;
  assign timer_busy = phase != ph_idle;

  a_no_start_busy: assert property (@(posedge clk) disable iff (!rst_n)
    elem.start |-> !elem.busy);

endmodule

// File: design/keyer_fsm.sv
`timescale 1ns/10ps

module keyer_fsm (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     dot_clean,
  input  logic     dash_clean,
  input  logic     cwx,
  keyer_cfg_if.snk cfg,
  element_if.ctrl  elem,
  output logic     keydown
);

  cw_keyer_pkg::keyer_state_e  state;
  cw_keyer_pkg::keyer_state_e  state_nxt;
  cw_keyer_pkg::element_kind_e last_kind;
  cw_keyer_pkg::element_kind_e next_kind;
  cw_keyer_pkg::element_kind_e other_kind;
  logic dot_mem;
  logic dash_mem;
  logic squeeze;   // Mode B squeeze seen during the mark
  logic is_straight;
  logic is_mode_b;
  logic want_dot;
  logic want_dash;
  logic go;
  logic mark_start;

  assign is_straight = cfg.mode == cw_keyer_pkg::mode_straight;
  assign is_mode_b   = cfg.mode == cw_keyer_pkg::mode_iambic_b;
  assign want_dot    = dot_clean | dot_mem;
  assign want_dash   = dash_clean | dash_mem;
  assign other_kind  = (last_kind == cw_keyer_pkg::elem_dot) ?
                       cw_keyer_pkg::elem_dash : cw_keyer_pkg::elem_dot;

  // Next mark after a space
  always_comb begin
    go        = 1'b1;
    next_kind = other_kind;
    if (want_dot && want_dash) next_kind = other_kind;  // Squeeze alternates
    else if (want_dot) next_kind = cw_keyer_pkg::elem_dot;
    else if (want_dash) next_kind = cw_keyer_pkg::elem_dash;
    else if (!(is_mode_b && squeeze)) go = 1'b0;
  end

  always_comb begin
    state_nxt  = state;
    elem.start = 1'b0;
    elem.kind  = next_kind;
    case (state)
      cw_keyer_pkg::st_idle: begin
        if (is_straight) begin
          state_nxt = cw_keyer_pkg::st_straight;
        end else if ((dot_clean || dash_clean) && !elem.busy) begin
          elem.start = 1'b1;
          elem.kind  = dot_clean ? cw_keyer_pkg::elem_dot : cw_keyer_pkg::elem_dash;
          state_nxt  = cw_keyer_pkg::st_mark;
        end
      end
      cw_keyer_pkg::st_straight: if (!is_straight) state_nxt = cw_keyer_pkg::st_idle;
      cw_keyer_pkg::st_mark: begin
        if (elem.done) begin
          elem.start = 1'b1;
          elem.kind  = cw_keyer_pkg::elem_space;
          state_nxt  = cw_keyer_pkg::st_gap;
        end
      end
      cw_keyer_pkg::st_gap: begin
        if (elem.done) begin
          if (go) begin
            elem.start = 1'b1;
            state_nxt  = cw_keyer_pkg::st_mark;
          end else if (cfg.spacing) begin
            elem.start = 1'b1;
            elem.kind  = cw_keyer_pkg::elem_letter_gap;
            state_nxt  = cw_keyer_pkg::st_letter;
          end else begin
            state_nxt = cw_keyer_pkg::st_idle;
          end
        end
      end
      default: if (elem.done) state_nxt = cw_keyer_pkg::st_idle;
    endcase
  end

  assign mark_start = elem.start && (state_nxt == cw_keyer_pkg::st_mark);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= cw_keyer_pkg::st_idle;
      keydown   <= 1'b0;
      last_kind <= cw_keyer_pkg::elem_dot;
      dot_mem   <= 1'b0;
      dash_mem  <= 1'b0;
      squeeze   <= 1'b0;
    end else begin
      state   <= state_nxt;
      keydown <= cwx || (state_nxt == cw_keyer_pkg::st_mark) ||
                 (state_nxt == cw_keyer_pkg::st_straight && dot_clean);
      if (mark_start) begin
        last_kind <= elem.kind;
        dot_mem   <= 1'b0;
        dash_mem  <= 1'b0;
        squeeze   <= 1'b0;
      end else if (state == cw_keyer_pkg::st_mark) begin
        // A lone tap on the other paddle is remembered
        if (last_kind == cw_keyer_pkg::elem_dash && dot_clean && !dash_clean) dot_mem <= 1'b1;
        if (last_kind == cw_keyer_pkg::elem_dot && dash_clean && !dot_clean) dash_mem <= 1'b1;
        if (is_mode_b && dot_clean && dash_clean) squeeze <= 1'b1;
      end
    end
  end

endmodule

// File: design/hang_timer.sv
`timescale 1ns/10ps

module hang_timer (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     keydown,
  input  logic     ms_tick,
  keyer_cfg_if.snk cfg,
  output logic     power_on
);

  logic [9:0] hang_cnt;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      hang_cnt <= '0;
    end else if (keydown) begin
      hang_cnt <= cfg.hang_ms;  // Reload while the carrier is keyed
    end else if (ms_tick && hang_cnt != '0) begin
      hang_cnt <= hang_cnt - 1'b1;
    end
  end

  assign power_on = keydown | (hang_cnt != '0);

  a_power_with_key: assert property (@(posedge clk) disable iff (!rst_n)
    keydown && cfg.hang_ms != '0 |=> power_on);

endmodule

// File: design/cw_keyer_top.sv
`timescale 1ns/10ps

module cw_keyer_top (
  input  logic        clk,
  input  logic        rst_n,
  input  logic [3:0]  awaddr,
  input  logic        awvalid,
  output logic        awready,
  input  logic [31:0] wdata,
  input  logic [3:0]  wstrb,
  input  logic        wvalid,
  output logic        wready,
  output logic [1:0]  bresp,
  output logic        bvalid,
  input  logic        bready,
  input  logic [3:0]  araddr,
  input  logic        arvalid,
  output logic        arready,
  output logic [31:0] rdata,
  output logic [1:0]  rresp,
  output logic        rvalid,
  input  logic        rready,
  input  logic        dot_key,
  input  logic        dash_key,
  input  logic        cwx,
  output logic        keydown,
  output logic        power_on
);

  logic dot_clean;
  logic dash_clean;
  logic ms_tick;
  logic timer_busy;

  keyer_cfg_if cfg_if ();
  element_if   elem_if ();

  keyer_regs u_regs (
    .clk, .rst_n,
    .awaddr, .awvalid, .awready, .wdata, .wstrb, .wvalid, .wready,
    .bresp, .bvalid, .bready,
    .araddr, .arvalid, .arready, .rdata, .rresp, .rvalid, .rready,
    .keydown, .power_on, .timer_busy,
    .cfg (cfg_if.src)
  );

  paddle_conditioner u_paddle (
    .clk, .rst_n, .dot_key, .dash_key,
    .cfg (cfg_if.snk),
    .dot_clean, .dash_clean
  );

  element_timer u_timer (
    .clk, .rst_n,
    .cfg  (cfg_if.snk),
    .elem (elem_if.timer),
    .ms_tick, .timer_busy
  );

  keyer_fsm u_fsm (
    .clk, .rst_n, .dot_clean, .dash_clean, .cwx,
    .cfg  (cfg_if.snk),
    .elem (elem_if.ctrl),
    .keydown
  );

  hang_timer u_hang (
    .clk, .rst_n, .keydown, .ms_tick,
    .cfg (cfg_if.snk),
    .power_on
  );

endmodule

// File: test/cw_keyer_tb.sv
`timescale 1ns/10ps

module cw_keyer_tb;

  localparam int max_wait = 20000;  // Cycles allowed for any single wait
  localparam int clks     = cw_keyer_pkg::clks_per_ms;
  localparam logic [3:0] bad_addr = 4'hE;  // No register decodes here

  logic        clk = 1'b0;
  logic        rst_n;
  logic [3:0]  awaddr;
  logic        awvalid;
  logic        awready;
  logic [31:0] wdata;
  logic [3:0]  wstrb;
  logic        wvalid;
  logic        wready;
  logic [1:0]  bresp;
  logic        bvalid;
  logic        bready;
  logic [3:0]  araddr;
  logic        arvalid;
  logic        arready;
  logic [31:0] rdata;
  logic [1:0]  rresp;
  logic        rvalid;
  logic        rready;
  logic        dot_key;
  logic        dash_key;
  logic        cwx;
  logic        keydown;
  logic        power_on;
  int          d_ms;          // Dot unit at the configured speed
  int          w_ms;          // Weighted dot
  int          quiet_cycles;  // Silence that ends a character

  cw_keyer_top DUT (.*);

  always #5 clk = ~clk;

  task automatic advance(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  task automatic check_value(input string name, input logic [31:0] expected,
                             input logic [31:0] actual);
    if (expected !== actual) begin
      $display("CHECK FAILED %s: expected %0d, actual %0d", name, expected, actual);
      $display("TEST FAILED");
      $fatal(1, "Stopped at the first error");
    end
  endtask

  task automatic timed_out(input string what);
    $display("Timed out while waiting for %s", what);
    $display("TEST FAILED");
    $fatal(1, "Stopped on a timeout");
  endtask

  task automatic axi_write(input logic [3:0] addr, input logic [31:0] data,
                           input logic [3:0] strb, output logic [1:0] resp);
    int n;
    awaddr  = addr;
    wdata   = data;
    wstrb   = strb;
    awvalid = 1'b1;
    wvalid  = 1'b1;
    n = 0;
    while (!(awready && wready)) begin
      advance(1);
      n++;
      if (n > max_wait) timed_out("awready and wready");
    end
    advance(1);
    awvalid = 1'b0;
    wvalid  = 1'b0;
    n = 0;
    while (!bvalid) begin
      advance(1);
      n++;
      if (n > max_wait) timed_out("bvalid");
    end
    resp   = bresp;
    bready = 1'b1;
    advance(1);
    bready = 1'b0;
  endtask

  task automatic axi_read(input logic [3:0] addr, output logic [31:0] data,
                          output logic [1:0] resp);
    int n;
    araddr  = addr;
    arvalid = 1'b1;
    n = 0;
    while (!arready) begin
      advance(1);
      n++;
      if (n > max_wait) timed_out("arready");
    end
    advance(1);
    arvalid = 1'b0;
    n = 0;
    while (!rvalid) begin
      advance(1);
      n++;
      if (n > max_wait) timed_out("rvalid");
    end
    data   = rdata;
    resp   = rresp;
    rready = 1'b1;
    advance(1);
    rready = 1'b0;
  endtask

  task automatic wait_timer_idle();
    logic [31:0] data;
    logic [1:0]  resp;
    int          n;
    data = 32'h4;
    n = 0;
    while (data[2]) begin
      axi_read(cw_keyer_pkg::reg_status, data, resp);
      n++;
      if (n > 200) timed_out("the element timer to finish its divide");
    end
  endtask

  task automatic configure(input int speed, input logic [1:0] mode, input logic rev,
                           input logic spacing, input int weight, input int hang);
    logic [1:0] resp;
    axi_write(cw_keyer_pkg::reg_ctrl, {22'd0, spacing, rev, mode, 6'(speed)}, 4'hF, resp);
    check_value("config ctrl", cw_keyer_pkg::axi_resp_okay, resp);
    axi_write(cw_keyer_pkg::reg_weight, 32'(weight), 4'hF, resp);
    check_value("config weight", cw_keyer_pkg::axi_resp_okay, resp);
    axi_write(cw_keyer_pkg::reg_hang, 32'(hang), 4'hF, resp);
    check_value("config hang", cw_keyer_pkg::axi_resp_okay, resp);
    wait_timer_idle();
    d_ms = cw_keyer_pkg::dot_constant / speed;
    w_ms = d_ms * weight / 50;
    quiet_cycles = 5 * d_ms * clks;
  endtask

  // keydown rises with busy and falls on the edge after done
  function automatic int mark_cycles(input int ms);
    return ms * clks + 1;
  endfunction

  task automatic wait_keydown(input logic level);
    int n;
    n = 0;
    while (keydown !== level) begin
      advance(1);
      n++;
      if (n > max_wait) timed_out("keydown to change");
    end
  endtask

  task automatic measure_mark(output int len);
    wait_keydown(1'b1);
    len = 0;
    while (keydown) begin
      advance(1);
      len++;
      if (len > max_wait) timed_out("the end of a mark");
    end
  endtask

  task automatic measure_gap(output int len);
    len = 0;
    while (!keydown) begin
      advance(1);
      len++;
      if (len > max_wait) timed_out("the next mark");
    end
  endtask

  // Counts marks until the key has stayed up for quiet_cycles
  task automatic count_marks(output int count, output int last_len);
    int low;
    int len;
    int n;
    count    = 0;
    last_len = 0;
    low      = 0;
    n        = 0;
    while (low < quiet_cycles) begin
      if (keydown) begin
        measure_mark(len);
        count++;
        last_len = len;
        low      = 0;
      end else begin
        advance(1);
        low++;
      end
      n++;
      if (n > max_wait) timed_out("the keyer to go quiet");
    end
  endtask

  task automatic register_access();
    logic [31:0] data;
    logic [31:0] rd;
    logic [31:0] exp_ctrl;
    logic [6:0]  wt;
    logic [1:0]  resp;
    exp_ctrl = '0;
    for (int i = 0; i < 4; i++) begin
      data = $urandom;
      axi_write(cw_keyer_pkg::reg_ctrl, data, 4'hF, resp);
      check_value("ctrl write resp", cw_keyer_pkg::axi_resp_okay, resp);
      exp_ctrl = {22'd0, data[9:6], (data[5:0] < 6'd5) ? 6'd5 : data[5:0]};
      axi_read(cw_keyer_pkg::reg_ctrl, rd, resp);
      check_value("ctrl readback", exp_ctrl, rd);
      data = $urandom;
      wt   = data[6:0];
      axi_write(cw_keyer_pkg::reg_weight, data, 4'hF, resp);
      check_value("weight write resp", cw_keyer_pkg::axi_resp_okay, resp);
      axi_read(cw_keyer_pkg::reg_weight, rd, resp);
      check_value("weight readback", (wt < 7'd33) ? 7'd33 : ((wt > 7'd66) ? 7'd66 : wt), rd);
      data = $urandom;
      axi_write(cw_keyer_pkg::reg_hang, data, 4'hF, resp);
      check_value("hang write resp", cw_keyer_pkg::axi_resp_okay, resp);
      axi_read(cw_keyer_pkg::reg_hang, rd, resp);
      check_value("hang readback", {22'd0, data[9:0]}, rd);
    end
    axi_write(cw_keyer_pkg::reg_status, $urandom, 4'hF, resp);
    check_value("status write resp", cw_keyer_pkg::axi_resp_slverr, resp);
    axi_write(bad_addr, $urandom, 4'hF, resp);
    check_value("unmapped write resp", cw_keyer_pkg::axi_resp_slverr, resp);
    axi_read(cw_keyer_pkg::reg_ctrl, rd, resp);
    check_value("ctrl after bad writes", exp_ctrl, rd);
    axi_read(bad_addr, rd, resp);
    check_value("unmapped read resp", cw_keyer_pkg::axi_resp_slverr, resp);
    check_value("unmapped read data", 0, rd);
  endtask

  task automatic straight_and_cwx();
    int n;
    configure(30, cw_keyer_pkg::mode_straight, 1'b0, 1'b0, 50, 0);
    dot_key = 1'b1;
    n = 0;
    while (!keydown) begin
      advance(1);
      n++;
      if (n > 100) timed_out("straight keydown to rise");
    end
    check_value("straight press latency", 2 + cw_keyer_pkg::debounce_cycles + 1, n);
    dot_key = 1'b0;
    n = 0;
    while (keydown) begin
      advance(1);
      n++;
      if (n > 100) timed_out("straight keydown to fall");
    end
    check_value("straight release latency", 2 + cw_keyer_pkg::debounce_cycles + 1, n);
    dot_key = 1'b1;
    advance(cw_keyer_pkg::debounce_cycles - 1);  // Just short of the debounce time
    dot_key = 1'b0;
    repeat (3 * cw_keyer_pkg::debounce_cycles) begin
      advance(1);
      check_value("paddle glitch", 0, keydown);
    end
    configure(30, cw_keyer_pkg::mode_iambic_a, 1'b0, 1'b0, 50, 0);
    cwx = 1'b1;
    advance(1);
    check_value("cwx press", 1, keydown);
    cwx = 1'b0;
    advance(1);
    check_value("cwx release", 0, keydown);
  endtask

  task automatic iambic_lengths(input int weight);
    int len;
    int cnt;
    int last;
    configure(30, cw_keyer_pkg::mode_iambic_a, 1'b0, 1'b0, weight, 0);
    dot_key = 1'b1;
    measure_mark(len);
    check_value($sformatf("dot mark w%0d", weight), mark_cycles(w_ms), len);
    measure_gap(len);
    check_value($sformatf("dot space w%0d", weight), mark_cycles(2 * d_ms - w_ms), len);
    dot_key = 1'b0;
    count_marks(cnt, last);
    check_value($sformatf("dot stop w%0d", weight), 1, cnt);
    dash_key = 1'b1;
    measure_mark(len);
    check_value($sformatf("dash mark w%0d", weight), mark_cycles(3 * d_ms + w_ms - d_ms), len);
    measure_gap(len);
    check_value($sformatf("dash space w%0d", weight), mark_cycles(2 * d_ms - w_ms), len);
    dash_key = 1'b0;
    count_marks(cnt, last);
    check_value($sformatf("dash stop w%0d", weight), 1, cnt);
  endtask

  task automatic squeeze_release(input logic [1:0] mode, input int extra);
    int cnt;
    int last;
    configure(30, mode, 1'b0, 1'b0, 50, 0);
    dash_key = 1'b1;
    wait_keydown(1'b1);
    advance(100);
    dot_key = 1'b1;   // Squeeze during the dash
    advance(100);
    dot_key  = 1'b0;
    dash_key = 1'b0;
    wait_keydown(1'b0);
    count_marks(cnt, last);
    check_value($sformatf("squeeze extra mode %0d", mode), extra, cnt);
    if (extra > 0) check_value("squeeze extra dot", mark_cycles(w_ms), last);
  endtask

  task automatic reverse_paddles();
    int len;
    int cnt;
    int last;
    configure(30, cw_keyer_pkg::mode_iambic_a, 1'b1, 1'b0, 50, 0);
    dot_key = 1'b1;
    measure_mark(len);
    check_value("reversed dot contact", mark_cycles(3 * d_ms + w_ms - d_ms), len);
    dot_key = 1'b0;
    count_marks(cnt, last);
    check_value("reversed stop", 0, cnt);
  endtask

  task automatic hang_window();
    int n;
    int lo;
    int hi;
    configure(30, cw_keyer_pkg::mode_straight, 1'b0, 1'b0, 50, 3);
    dot_key = 1'b1;
    wait_keydown(1'b1);
    dot_key = 1'b0;
    wait_keydown(1'b0);
    n = 0;
    while (power_on) begin
      advance(1);
      n++;
      if (n > max_wait) timed_out("power_on to fall");
    end
    lo = 2 * clks;
    hi = 3 * clks + 2;
    if (n < lo) check_value("hang fall early", lo, n);
    if (n > hi) check_value("hang fall late", hi, n);
  endtask

  task automatic letter_spacing();
    int space;
    int len;
    int lo;
    int cnt;
    int last;
    configure(30, cw_keyer_pkg::mode_iambic_a, 1'b0, 1'b1, 50, 0);
    dot_key = 1'b1;
    wait_keydown(1'b1);
    advance(100);
    dot_key = 1'b0;
    wait_keydown(1'b0);
    space = mark_cycles(2 * d_ms - w_ms);
    advance(space + 50);
    dot_key = 1'b1;   // Next character pressed during the letter gap
    measure_gap(len);
    len = len + space + 50;
    lo  = space + 2 * d_ms * clks;
    if (len < lo) check_value("letter gap", lo, len);
    dot_key = 1'b0;
    count_marks(cnt, last);
  endtask

  initial begin
    rst_n    = 1'b0;
    awaddr   = '0;
    awvalid  = 1'b0;
    wdata    = '0;
    wstrb    = '0;
    wvalid   = 1'b0;
    bready   = 1'b0;
    araddr   = '0;
    arvalid  = 1'b0;
    rready   = 1'b0;
    dot_key  = 1'b0;
    dash_key = 1'b0;
    cwx      = 1'b0;
    void'($urandom(32'h2bb3_f7a5));
    repeat (4) @(posedge clk);
    #1;
    rst_n = 1'b1;
    check_value("reset keydown", 0, keydown);
    check_value("reset power_on", 0, power_on);
    check_value("reset bvalid", 0, bvalid);
    check_value("reset rvalid", 0, rvalid);
    check_value("reset awready", 0, awready);
    check_value("reset wready", 0, wready);
    check_value("reset arready", 0, arready);
    register_access();
    straight_and_cwx();
    iambic_lengths(50);
    iambic_lengths(60);
    squeeze_release(cw_keyer_pkg::mode_iambic_a, 0);
    squeeze_release(cw_keyer_pkg::mode_iambic_b, 1);
    reverse_paddles();
    hang_window();
    letter_spacing();
    $display("TEST OK");
    $finish;
  end

endmodule

// File: cw_keyer.f
design/cw_keyer_pkg.sv
design/keyer_cfg_if.sv
design/element_if.sv
design/keyer_regs.sv
design/paddle_conditioner.sv
design/element_timer.sv
design/keyer_fsm.sv
design/hang_timer.sv
design/cw_keyer_top.sv
test/cw_keyer_tb.sv

// File: run_sim.sh
#!/bin/sh
# Compile and run the CW keyer testbench with Verilator

cd "$(dirname "$0")" || exit 1

build_log=build.log
sim_log=sim.log

verilator --binary --timing --assert -Wno-fatal \
  --top-module cw_keyer_tb -f cw_keyer.f > "$build_log" 2>&1
if [ $? -ne 0 ]; then
  echo "Build failed, see $build_log"
  exit 1
fi

./obj_dir/Vcw_keyer_tb > "$sim_log" 2>&1
sim_status=$?

if grep -q "TEST FAILED" "$sim_log"; then
  echo "Simulation failed, see $sim_log"
  exit 1
fi
if [ $sim_status -ne 0 ]; then
  echo "Simulator exited with status $sim_status, see $sim_log"
  exit 1
fi
if ! grep -q "TEST OK" "$sim_log"; then
  echo "Simulation ended without a result, see $sim_log"
  exit 1
fi
echo "Simulation passed"
exit 0
